/* logic/l2_write_pkg.sv */
package l2_write_pkg;

    // a line holds 1 << OFFSET_WIDTH words.
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
    localparam int WORD_BITS = 32;
    localparam int LINE_BITS = LINE_WORDS * WORD_BITS;

    // index of the word that carries wlast in a line burst.
    localparam logic [OFFSET_WIDTH-1:0] LAST_BEAT = OFFSET_WIDTH'(LINE_WORDS - 1);

    // the bus length field counts beats minus one.
    localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);
    localparam logic [7:0] SINGLE_LEN = 8'd0;

    localparam logic [3:0] FULL_STRB = 4'hF;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // the DMA states carry one uncached store; WRT_W is the line handoff.
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        DMA_AW = 4'd1,
        DMA_W  = 4'd2,
        DMA_R  = 4'd3,
        WRT_W  = 4'd4
    } wr_state_t;

endpackage

/* logic/write_ctrl.sv */
module write_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_w,
    input  logic                    dma_sign,
    input  logic                    buf_busy,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    bvalid,
    output l2_write_pkg::wr_state_t crt,
    output l2_write_pkg::wr_state_t nxt
);
    import l2_write_pkg::*;

    logic dma_req;
    logic line_req;

    assign dma_req = req_w && dma_sign;
    assign line_req = req_w && !dma_sign;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crt <= IDLE;
        end else begin
            crt <= nxt;
        end
    end

    always_comb begin
        nxt = crt;
        case (crt)
            IDLE: begin
                // an uncached store must not overtake a line still in the buffer.
                if (dma_req) begin
                    if (!buf_busy) begin
                        nxt = DMA_AW;
                    end
                end else if (line_req) begin
                    nxt = WRT_W;
                end
            end
            DMA_AW: begin
                if (awready) begin
                    nxt = DMA_W;
                end
            end
            DMA_W: begin
                if (wready) begin
                    nxt = DMA_R;
                end
            end
            DMA_R: begin
                if (bvalid) begin
                    nxt = IDLE;
                end
            end
            WRT_W: begin
                // stay here while a further line waits for the buffer.
                if (!line_req) begin
                    nxt = IDLE;
                end
            end
            default: begin
                nxt = IDLE;
            end
        endcase
    end

    // the uncached sequence owns the bus only while the write buffer is drained.
    assert property (@(posedge clk) disable iff (!rst_n)
        (crt inside {DMA_AW, DMA_W, DMA_R}) |-> !buf_busy);

endmodule

/* logic/write_buffer.sv */
module write_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                buf_req,
    input  l2_write_pkg::word_t buf_addr,
    input  l2_write_pkg::line_t buf_line,
    output logic                buf_accept,
    output logic                buf_busy,
    output l2_write_pkg::word_t awaddr,
    output logic                awvalid,
    input  logic                awready,
    output l2_write_pkg::word_t wdata,
    output logic                wvalid,
    output logic                wlast,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);
    import l2_write_pkg::*;

    word_t                   addr_q;
    line_t                   line_q;
    logic [OFFSET_WIDTH-1:0] beat;
    logic                    busy_q;
    logic                    aw_pend;
    logic                    w_pend;
    logic                    b_pend;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;
    logic                    at_last;

    // a new line is taken only when the previous one has fully retired.
    assign buf_accept = buf_req && !busy_q;
    assign buf_busy = busy_q;

    assign aw_fire = aw_pend && awready;
    assign w_fire = w_pend && wready;
    assign b_fire = b_pend && bvalid;
    assign at_last = (beat == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (buf_accept) begin
            addr_q <= buf_addr;
            line_q <= buf_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            aw_pend <= 1'b0;
            w_pend <= 1'b0;
            b_pend <= 1'b0;
            beat <= '0;
        end else begin
            if (buf_accept) begin
                busy_q <= 1'b1;
                aw_pend <= 1'b1;
                beat <= '0;
            end
            if (aw_fire) begin
                aw_pend <= 1'b0;
                w_pend <= 1'b1;
            end
            // the word index moves only on a data handshake.
            if (w_fire) begin
                if (at_last) begin
                    w_pend <= 1'b0;
                    b_pend <= 1'b1;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
            if (b_fire) begin
                b_pend <= 1'b0;
                busy_q <= 1'b0;
            end
        end
    end

    assign awaddr = addr_q;
    assign awvalid = aw_pend;

    // word 0 sits in the low bits of the line.
    assign wdata = line_q[beat*WORD_BITS +: WORD_BITS];
    assign wvalid = w_pend;
    assign wlast = w_pend && at_last;

    assign bready = b_pend;

    // no second line is accepted until the response of the first has been taken.
    assert property (@(posedge clk) disable iff (!rst_n)
        buf_accept |=> !buf_accept until_with (bvalid && bready));

endmodule

/* logic/write_arbiter.sv */
module write_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l2_write_pkg::wr_state_t crt,
    // cache request
    input  l2_write_pkg::word_t     addr_w,
    input  l2_write_pkg::line_t     line_w,
    input  logic [3:0]              strb_w,
    input  logic                    req_w,
    input  logic                    dma_sign,
    output logic                    addr_ok_w,
    // write buffer
    output logic                    buf_req,
    output l2_write_pkg::word_t     buf_addr,
    output l2_write_pkg::line_t     buf_line,
    input  logic                    buf_accept,
    input  l2_write_pkg::word_t     buf_awaddr,
    input  logic                    buf_awvalid,
    output logic                    buf_awready,
    input  l2_write_pkg::word_t     buf_wdata,
    input  logic                    buf_wvalid,
    input  logic                    buf_wlast,
    output logic                    buf_wready,
    input  logic                    buf_bready,
    output logic                    buf_bvalid,
    // memory bus
    output l2_write_pkg::word_t     awaddr,
    output logic [7:0]              awlen,
    output logic                    awvalid,
    input  logic                    awready,
    output l2_write_pkg::word_t     wdata,
    output logic [3:0]              wstrb,
    output logic                    wvalid,
    output logic                    wlast,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);
    import l2_write_pkg::*;

    always_comb begin
        addr_ok_w = 1'b0;

        buf_req = 1'b0;
        buf_addr = '0;
        buf_line = '0;
        buf_awready = 1'b0;
        buf_wready = 1'b0;
        buf_bvalid = 1'b0;

        awaddr = '0;
        awlen = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        wlast = 1'b0;
        bready = 1'b0;

        case (crt)
            IDLE, WRT_W: begin
                // uncached requests are held back from the buffer.
                buf_req = req_w && !dma_sign;
                buf_addr = addr_w;
                buf_line = line_w;
                addr_ok_w = buf_accept;

                awlen = BURST_LEN;
                wstrb = FULL_STRB;

                awaddr = buf_awaddr;
                awvalid = buf_awvalid;
                wdata = buf_wdata;
                wvalid = buf_wvalid;
                wlast = buf_wlast;
                bready = buf_bready;

                buf_awready = awready;
                buf_wready = wready;
                buf_bvalid = bvalid;
            end
            DMA_AW: begin
                awaddr = addr_w;
                awlen = SINGLE_LEN;
                awvalid = 1'b1;
                wstrb = strb_w;
            end
            DMA_W: begin
                awlen = SINGLE_LEN;
                wdata = line_w[WORD_BITS-1:0];
                wstrb = strb_w;
                wvalid = 1'b1;
                wlast = 1'b1;
            end
            DMA_R: begin
                // the cache is released only once memory has answered.
                addr_ok_w = bvalid;
                awlen = SINGLE_LEN;
                wstrb = strb_w;
                bready = 1'b1;
            end
            default: begin
                addr_ok_w = 1'b0;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) wlast |-> wvalid);

    // a stalled beat keeps its data and last flag across the state steer.
    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

endmodule

/* logic/l2_write_path.sv */
module l2_write_path (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_w,
    input  logic                dma_sign,
    input  l2_write_pkg::word_t addr_w,
    input  l2_write_pkg::line_t line_w,
    input  logic [3:0]          strb_w,
    output logic                addr_ok_w,
    output l2_write_pkg::word_t awaddr,
    output logic [7:0]          awlen,
    output logic                awvalid,
    input  logic                awready,
    output l2_write_pkg::word_t wdata,
    output logic [3:0]          wstrb,
    output logic                wvalid,
    output logic                wlast,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);
    import l2_write_pkg::*;

    wr_state_t crt;

    logic  buf_req;
    word_t buf_addr;
    line_t buf_line;
    logic  buf_accept;
    logic  buf_busy;
    word_t buf_awaddr;
    logic  buf_awvalid;
    logic  buf_awready;
    word_t buf_wdata;
    logic  buf_wvalid;
    logic  buf_wlast;
    logic  buf_wready;
    logic  buf_bready;
    logic  buf_bvalid;

    // the controller watches the shared bus directly.
    write_ctrl u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .req_w(req_w),
        .dma_sign(dma_sign),
        .buf_busy(buf_busy),
        .awready(awready),
        .wready(wready),
        .bvalid(bvalid),
        .crt(crt),
        .nxt()
    );

    write_buffer u_buffer (
        .clk(clk),
        .rst_n(rst_n),
        .buf_req(buf_req),
        .buf_addr(buf_addr),
        .buf_line(buf_line),
        .buf_accept(buf_accept),
        .buf_busy(buf_busy),
        .awaddr(buf_awaddr),
        .awvalid(buf_awvalid),
        .awready(buf_awready),
        .wdata(buf_wdata),
        .wvalid(buf_wvalid),
        .wlast(buf_wlast),
        .wready(buf_wready),
        .bvalid(buf_bvalid),
        .bready(buf_bready)
    );

    write_arbiter u_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .crt(crt),
        .addr_w(addr_w),
        .line_w(line_w),
        .strb_w(strb_w),
        .req_w(req_w),
        .dma_sign(dma_sign),
        .addr_ok_w(addr_ok_w),
        .buf_req(buf_req),
        .buf_addr(buf_addr),
        .buf_line(buf_line),
        .buf_accept(buf_accept),
        .buf_awaddr(buf_awaddr),
        .buf_awvalid(buf_awvalid),
        .buf_awready(buf_awready),
        .buf_wdata(buf_wdata),
        .buf_wvalid(buf_wvalid),
        .buf_wlast(buf_wlast),
        .buf_wready(buf_wready),
        .buf_bready(buf_bready),
        .buf_bvalid(buf_bvalid),
        .awaddr(awaddr),
        .awlen(awlen),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wlast(wlast),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready)
    );

endmodule

/* tb/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD = 20,
    parameter int RESET_CYCLES = 8,
    parameter int DRIVE_DELAY = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is released just after a rising edge, in step with the other inputs.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
    end

endmodule

/* tb/tb_l2_write_path.sv */
module tb_l2_write_path;
    import l2_write_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY = 2;
    localparam int CYCLES_PER_RECORD = 40;

    logic       clk;
    logic       rst_n;
    logic       req_w;
    logic       dma_sign;
    word_t      addr_w;
    line_t      line_w;
    logic [3:0] strb_w;
    logic       addr_ok_w;
    word_t      awaddr;
    logic [7:0] awlen;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wlast;
    logic       wready;
    logic       bvalid;
    logic       bready;

    // requests and the bus traffic expected for them are kept in file order.
    logic       req_kind[$];
    word_t      req_addr[$];
    logic [3:0] req_strb[$];
    line_t      req_line[$];
    int         req_beat_end[$];
    word_t      exp_awaddr[$];
    logic [7:0] exp_awlen[$];
    word_t      exp_wdata[$];
    logic [3:0] exp_wstrb[$];
    logic       exp_wlast[$];

    int     mismatch_count = 0;
    int     error_count = 0;
    int     aws_seen = 0;
    int     beats_seen = 0;
    int     resps_seen = 0;
    int     acks_seen = 0;
    integer seed = 32'he3535fb7;
    bit     vectors_loaded = 1'b0;

    clk_gen #(
        .PERIOD(CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES),
        .DRIVE_DELAY(DRIVE_DELAY)
    ) u_clk_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    l2_write_path DUT (.*);

    task automatic check_addr(input word_t exp_addr, input word_t act_addr,
                              input logic [7:0] exp_len, input logic [7:0] act_len);
        if (act_addr !== exp_addr) begin
            $display("Mismatch at %0t: awaddr expected %h got %h", $time, exp_addr, act_addr);
            mismatch_count++;
        end
        if (act_len !== exp_len) begin
            $display("Mismatch at %0t: awlen expected %h got %h", $time, exp_len, act_len);
            mismatch_count++;
        end
    endtask

    task automatic check_beat(input word_t exp_data, input word_t act_data,
                              input logic [3:0] exp_strb, input logic [3:0] act_strb,
                              input logic exp_last, input logic act_last);
        if (act_data !== exp_data) begin
            $display("Mismatch at %0t: wdata expected %h got %h", $time, exp_data, act_data);
            mismatch_count++;
        end
        if (act_strb !== exp_strb) begin
            $display("Mismatch at %0t: wstrb expected %h got %h", $time, exp_strb, act_strb);
            mismatch_count++;
        end
        if (act_last !== exp_last) begin
            $display("Mismatch at %0t: wlast expected %b got %b", $time, exp_last, act_last);
            mismatch_count++;
        end
    endtask

    task automatic check_ack(input int exp_count, input int act_count);
        if (act_count != exp_count) begin
            $display("Mismatch at %0t: addr_ok_w pulses expected %0d got %0d",
                     $time, exp_count, act_count);
            mismatch_count++;
        end
    endtask

    task automatic check_low(input string name, input logic act);
        if (act !== 1'b0) begin
            $display("Mismatch at %0t: %s expected 0 got %b", $time, name, act);
            mismatch_count++;
        end
    endtask

    task automatic read_vectors(output bit ok);
        int         fd;
        int         code;
        int         ch;
        int         beat_total;
        string      tag;
        logic       kind;
        word_t      value;
        logic [3:0] strb;
        logic [7:0] len;
        logic       last;
        line_t      line_val;
        beat_total = 0;
        fd = $fopen("tb/l2_write_golden.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (tag == "R") begin
                    code = $fscanf(fd, "%h %h %h %h", kind, value, strb, line_val);
                    req_kind.push_back(kind);
                    req_addr.push_back(value);
                    req_strb.push_back(strb);
                    req_line.push_back(line_val);
                    req_beat_end.push_back(beat_total);
                end else if (tag == "A") begin
                    code = $fscanf(fd, "%h %h", value, len);
                    exp_awaddr.push_back(value);
                    exp_awlen.push_back(len);
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%h %h %h", value, strb, last);
                    exp_wdata.push_back(value);
                    exp_wstrb.push_back(strb);
                    exp_wlast.push_back(last);
                    beat_total++;
                    req_beat_end[req_beat_end.size() - 1] = beat_total;
                end else begin
                    $display("golden file holds an unknown record tag %s", tag);
                    error_count++;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    // holds the request until addr_ok_w is seen, then drops it after that edge.
    task automatic issue_request(input int idx);
        bit acked;
        acked = 1'b0;
        req_w = 1'b1;
        dma_sign = req_kind[idx];
        addr_w = req_addr[idx];
        line_w = req_line[idx];
        strb_w = req_strb[idx];
        while (!acked) begin
            @(negedge clk);
            if (addr_ok_w === 1'b1) begin
                acked = 1'b1;
                if (dma_sign && !(bvalid && bready)) begin
                    $display("uncached write %0d acknowledged at %0t without a write response",
                             idx, $time);
                    error_count++;
                end
                if (dma_sign && beats_seen != req_beat_end[idx]) begin
                    $display("uncached write %0d acknowledged at %0t before its data beat",
                             idx, $time);
                    error_count++;
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req_w = 1'b0;
        dma_sign = 1'b0;
    endtask

    // the memory side is sampled on the falling edge where every handshake input is settled.
    always @(negedge clk) begin
        if (rst_n) begin
            if (awvalid && awready) begin
                if (aws_seen != resps_seen) begin
                    $display("address %h issued at %0t while a write still awaits its response",
                             awaddr, $time);
                    error_count++;
                end
                if (exp_awaddr.size() == 0) begin
                    $display("unexpected address %h on the bus at %0t", awaddr, $time);
                    error_count++;
                end else begin
                    check_addr(exp_awaddr.pop_front(), awaddr, exp_awlen.pop_front(), awlen);
                end
                aws_seen++;
            end
            if (wvalid && wready) begin
                if (exp_wdata.size() == 0) begin
                    $display("unexpected data beat %h on the bus at %0t", wdata, $time);
                    error_count++;
                end else begin
                    check_beat(exp_wdata.pop_front(), wdata, exp_wstrb.pop_front(), wstrb,
                               exp_wlast.pop_front(), wlast);
                end
                beats_seen++;
            end
            if (bvalid && bready) begin
                resps_seen++;
            end
            if (addr_ok_w) begin
                acks_seen++;
            end
        end
    end

    initial begin : memory_responder
        logic last_hs;
        logic b_hs;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        forever begin
            @(negedge clk);
            last_hs = rst_n && wvalid && wready && wlast;
            b_hs = rst_n && bvalid && bready;
            @(posedge clk);
            #DRIVE_DELAY;
            if (!rst_n) begin
                awready = 1'b0;
                wready = 1'b0;
                bvalid = 1'b0;
            end else begin
                if (b_hs) begin
                    bvalid = 1'b0;
                end
                if (last_hs) begin
                    bvalid = 1'b1;
                end
                // roughly one cycle in four stalls each channel.
                awready = ($random(seed) & 3) != 0;
                wready = ($random(seed) & 3) != 0;
            end
        end
    end

    initial begin : stimulus
        bit ok;
        req_w = 1'b0;
        dma_sign = 1'b0;
        addr_w = '0;
        line_w = '0;
        strb_w = '0;
        read_vectors(ok);
        vectors_loaded = 1'b1;
        if (!ok) begin
            $display("cannot open tb/l2_write_golden.txt");
            error_count++;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_low("awvalid", awvalid);
        check_low("wvalid", wvalid);
        check_low("wlast", wlast);
        check_low("bready", bready);
        check_low("addr_ok_w", addr_ok_w);
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < req_kind.size(); i++) begin
            issue_request(i);
        end
        while (resps_seen < req_kind.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check_ack(req_kind.size(), acks_seen);
        if (exp_awaddr.size() != 0 || exp_wdata.size() != 0) begin
            $display("%0d addresses and %0d data beats never reached the bus",
                     exp_awaddr.size(), exp_wdata.size());
            error_count++;
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (vectors_loaded);
        #((RESET_CYCLES + req_kind.size() * CYCLES_PER_RECORD) * CLK_PERIOD);
        $display("timeout at %0t with %0d of %0d writes answered",
                 $time, resps_seen, req_kind.size());
        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        $display("Test failed");
        $finish;
    end

endmodule

/* tb/l2_write_golden.txt */
# R kind(0 line, 1 uncached) addr strb line, followed by the expected bus beats in order:
# A awaddr awlen for the address, W wdata wstrb wlast for each data beat.
R 0 00001000 f 44440004333300032222000211110001
A 00001000 03
W 11110001 f 0
W 22220002 f 0
W 33330003 f 0
W 44440004 f 1
R 1 80000010 3 dead0003dead0002dead00015a5a00c3
A 80000010 00
W 5a5a00c3 3 1
R 0 00002040 f d4d4d4d4c3c3c3c3b2b2b2b2a1a1a1a1
A 00002040 03
W a1a1a1a1 f 0
W b2b2b2b2 f 0
W c3c3c3c3 f 0
W d4d4d4d4 f 1
R 0 00003080 f 0f0e0d0c0b0a09080706050403020100
A 00003080 03
W 03020100 f 0
W 07060504 f 0
W 0b0a0908 f 0
W 0f0e0d0c f 1
R 1 80000024 c 77777777666666665555555512345678
A 80000024 00
W 12345678 c 1

/* sim.f */
logic/l2_write_pkg.sv
logic/write_ctrl.sv
logic/write_buffer.sv
logic/write_arbiter.sv
logic/l2_write_path.sv
tb/clk_gen.sv
tb/tb_l2_write_path.sv

/* Bender.yml */
package:
  name: l2_write_path

sources:
  - logic/l2_write_pkg.sv
  - logic/write_ctrl.sv
  - logic/write_buffer.sv
  - logic/write_arbiter.sv
  - logic/l2_write_path.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_l2_write_path.sv
